/* program.mem */
// one line per physical segment, 16 words each
// word = e000 + segment * 0100 + physical address
e000 e001 e002 e003 e004 e005 e006 e007 e008 e009 e00a e00b e00c e00d e00e e00f
e110 e111 e112 e113 e114 e115 e116 e117 e118 e119 e11a e11b e11c e11d e11e e11f
e220 e221 e222 e223 e224 e225 e226 e227 e228 e229 e22a e22b e22c e22d e22e e22f
e330 e331 e332 e333 e334 e335 e336 e337 e338 e339 e33a e33b e33c e33d e33e e33f
e440 e441 e442 e443 e444 e445 e446 e447 e448 e449 e44a e44b e44c e44d e44e e44f
e550 e551 e552 e553 e554 e555 e556 e557 e558 e559 e55a e55b e55c e55d e55e e55f

/* fetch_trace.txt */
# pkt <pc> <word1> <word2>, all hex, one line per packet in send order
# chars <string>, the full uart character string
# page 2 lives in segment 2
pkt 20 e220 e221
pkt 22 e222 e223
pkt 24 e224 e225
pkt 26 e226 e227
pkt 28 e228 e229
pkt 2a e22a e22b
pkt 2c e22c e22d
pkt 2e e22e e22f
# page 3 lives in segment 5
pkt 30 e550 e551
pkt 32 e552 e553
pkt 34 e554 e555
pkt 36 e556 e557
pkt 38 e558 e559
pkt 3a e55a e55b
pkt 3c e55c e55d
pkt 3e e55e e55f
# start char, then one a and one b per packet
chars Sabababababababababababababababab

/* filelist.f */
fetch_pkg.sv
mmu_walker.sv
program_ram.sv
char_fifo.sv
uart_tx.sv
fetch_ctrl.sv
fetch_top.sv
tb_fetch.sv

/* tb_fetch.sv */
`timescale 1ns/100ps

module tb_fetch;

  logic                  clk;
  logic                  rst_n;
  logic                  credit_return;
  fetch_pkg::fetch_pkt_t pkt;
  logic                  pkt_valid;
  logic                  halted;
  logic                  tx;

  fetch_pkg::fetch_pkt_t exp_pkts[$];   // from the trace file
  fetch_pkg::char_t      exp_chars[$];
  int                    due_q[$];      // cycle at which each credit goes back
  int                    cyc;
  int                    outstanding;   // packets the consumer still holds
  int                    fails;
  logic                  withhold;      // consumer keeps its credits
  int unsigned           rand_state;

  fetch_top #(
    .INIT_CREDITS (2),
    .CLKS_PER_BIT (4)
  ) u_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .credit_return (credit_return),
    .pkt           (pkt),
    .pkt_valid     (pkt_valid),
    .halted        (halted),
    .tx            (tx)
  );

  always #20 clk = ~clk;  // 40 ns period

  task abort_run;
    $display("Something failed");
    $fatal(1);
  endtask

  task check_pkt(input string name, input fetch_pkg::fetch_pkt_t exp,
                 input fetch_pkg::fetch_pkt_t act);
    if (exp !== act) begin
      fails++;
      $display("ERR %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task check_char(input string name, input fetch_pkg::char_t exp,
                  input fetch_pkg::char_t act);
    if (exp !== act) begin
      fails++;
      $display("ERR %s expected %h (%c) actual %h (%c)", name, exp, exp, act, act);
      abort_run();
    end
  endtask

  task check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      fails++;
      $display("ERR %s expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  // lcg, delay 0..9 cycles
  function int credit_delay();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return int'((rand_state >> 16) % 10);
  endfunction

  task load_trace;
    integer                fd;
    integer                code;
    integer                i;
    reg [8*96-1:0]         line;
    reg [8*8-1:0]          tag;
    reg [8*48-1:0]         text;
    logic [31:0]           pc_v;
    logic [31:0]           w1_v;
    logic [31:0]           w2_v;
    fetch_pkg::fetch_pkt_t p;
    fd = $fopen("fetch_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open fetch_trace.txt");
      abort_run();
    end
    while (!$feof(fd)) begin
      line = '0;
      tag  = '0;
      code = $fgets(line, fd);
      code = $sscanf(line, "%s", tag);  // first word picks the line kind
      if (tag == "pkt") begin
        code    = $sscanf(line, "%s %h %h %h", tag, pc_v, w1_v, w2_v);
        p.pc    = fetch_pkg::laddr_t'(pc_v);
        p.word1 = fetch_pkg::word_t'(w1_v);
        p.word2 = fetch_pkg::word_t'(w2_v);
        exp_pkts.push_back(p);
      end else if (tag == "chars") begin
        text = '0;
        code = $sscanf(line, "%s %s", tag, text);
        for (i = 47; i >= 0; i--) begin
          if (text[8*i +: 8] != 8'h00) exp_chars.push_back(text[8*i +: 8]);  // leading zeros skipped
        end
      end
    end
    $fclose(fd);
    if (exp_pkts.size() == 0 || exp_chars.size() == 0) begin
      $display("trace file holds no packets or no characters");
      abort_run();
    end
  endtask

  // consumer side, counts what it holds and schedules the credit returns
  always @(negedge clk) begin
    if (rst_n) begin
      if (pkt_valid === 1'b1) begin
        due_q.push_back(cyc + credit_delay());
        outstanding++;
      end
      if (credit_return) outstanding--;
      if (outstanding > 2) begin
        $display("more than 2 packets outstanding, credit limit broken");
        abort_run();
      end
    end
  end

  always @(posedge clk) begin
    cyc = cyc + 1;
    #2;
    credit_return = 1'b0;
    if (!withhold && due_q.size() > 0 && due_q[0] <= cyc) begin
      credit_return = 1'b1;  // one credit per cycle
      void'(due_q.pop_front());
    end
  end

  // 8N1 receiver, samples near the middle of each bit
  task receive_char(output fetch_pkg::char_t c);
    int t;
    int i;
    t = 0;
    while (tx !== 1'b0) begin
      if (t >= 3000) begin
        $display("no start bit on tx within 3000 cycles");
        abort_run();
      end
      t++;
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
    check_bit("uart start bit", 1'b0, tx);
    for (i = 0; i < 8; i++) begin
      repeat (4) @(negedge clk);
      c[i] = tx;  // lsb first
    end
    repeat (4) @(negedge clk);
    check_bit("uart stop bit", 1'b1, tx);
  endtask

  task run_uart;
    fetch_pkg::char_t c;
    int               k;
    for (k = 0; k < exp_chars.size(); k++) begin
      receive_char(c);
      check_char($sformatf("char %0d", k), exp_chars[k], c);
    end
  endtask

  task wait_packet(input int idx);
    int t;
    t = 0;
    @(negedge clk);
    while (pkt_valid !== 1'b1) begin
      check_bit("halted before last packet", 1'b0, halted);
      if (t >= 1000) begin
        $display("packet %0d did not arrive within 1000 cycles", idx);
        abort_run();
      end
      t++;
      @(negedge clk);
    end
  endtask

  task run_packets;
    int i;
    int t;
    for (i = 0; i < exp_pkts.size(); i++) begin
      wait_packet(i);
      check_pkt($sformatf("packet %0d", i), exp_pkts[i], pkt);
      if (i == 1) begin
        // both credits spent, nothing may leave
        repeat (50) begin
          @(negedge clk);
          check_bit("pkt_valid without credit", 1'b0, pkt_valid);
        end
        withhold = 1'b0;
      end
    end
    t = 0;
    while (halted !== 1'b1) begin
      if (t >= 100) begin
        $display("halted did not rise after the last packet");
        abort_run();
      end
      t++;
      @(negedge clk);
    end
    repeat (200) begin
      @(negedge clk);
      check_bit("pkt_valid after halt", 1'b0, pkt_valid);
      check_bit("halted held", 1'b1, halted);
    end
  endtask

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    credit_return = 1'b0;
    withhold      = 1'b1;  // released after the first two packets
    cyc           = 0;
    outstanding   = 0;
    fails         = 0;
    rand_state    = 91;
    load_trace();
    repeat (4) @(negedge clk);
    check_bit("pkt_valid in reset", 1'b0, pkt_valid);
    check_bit("halted in reset", 1'b0, halted);
    check_bit("tx in reset", 1'b1, tx);
    repeat (4) @(posedge clk);  // 8 cycles in reset
    #2 rst_n = 1'b1;
    @(negedge clk);
    check_bit("pkt_valid after reset", 1'b0, pkt_valid);
    check_bit("halted after reset", 1'b0, halted);
    check_bit("tx after reset", 1'b1, tx);
    fork
      run_uart();
      run_packets();
    join
    if (fails == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

/* fetch_top.sv */
`timescale 1ns/100ps

module fetch_top #(
  parameter int INIT_CREDITS = 2,
  parameter int CLKS_PER_BIT = 868,  // 100 MHz / 115200
  parameter int PROG_START   = 32,
  parameter int PROG_END     = 63
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  credit_return,
  output fetch_pkg::fetch_pkt_t pkt,
  output logic                  pkt_valid,
  output logic                  halted,
  output logic                  tx
);

  // controller <-> mmu
  logic              xlat_req;
  fetch_pkg::laddr_t xlat_addr;
  logic              xlat_done;
  fetch_pkg::paddr_t xlat_paddr;

  // controller <-> program memory
  logic              rd_en;
  fetch_pkg::paddr_t rd_addr;
  fetch_pkg::word_t  rd_data;

  // trace path, controller -> fifo -> uart
  logic              ch_push;
  fetch_pkg::char_t  ch_data;
  logic              ch_full;
  logic              ch_valid;
  fetch_pkg::char_t  ch_head;
  logic              ch_pop;

  fetch_ctrl #(
    .INIT_CREDITS (INIT_CREDITS),
    .PROG_START   (PROG_START),
    .PROG_END     (PROG_END)
  ) u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .credit_return (credit_return),
    .pkt           (pkt),
    .pkt_valid     (pkt_valid),
    .halted        (halted),
    .xlat_req      (xlat_req),
    .xlat_addr     (xlat_addr),
    .xlat_done     (xlat_done),
    .xlat_paddr    (xlat_paddr),
    .rd_en         (rd_en),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data),
    .ch_push       (ch_push),
    .ch_data       (ch_data),
    .ch_full       (ch_full)
  );

  mmu_walker #(
    .PAGE_WORDS (fetch_pkg::PAGE_WORDS)
  ) u_mmu (
    .clk        (clk),
    .rst_n      (rst_n),
    .xlat_req   (xlat_req),
    .xlat_addr  (xlat_addr),
    .xlat_done  (xlat_done),
    .xlat_paddr (xlat_paddr)
  );

  program_ram u_ram (
    .clk     (clk),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  char_fifo #(
    .DEPTH (16)
  ) u_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .ch_push  (ch_push),
    .ch_data  (ch_data),
    .ch_full  (ch_full),
    .ch_valid (ch_valid),
    .ch_head  (ch_head),
    .ch_pop   (ch_pop)
  );

  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_uart (
    .clk      (clk),
    .rst_n    (rst_n),
    .ch_valid (ch_valid),
    .ch_head  (ch_head),
    .ch_pop   (ch_pop),
    .tx       (tx)
  );

endmodule

/* fetch_ctrl.sv */
`timescale 1ns/100ps

module fetch_ctrl #(
  parameter int INIT_CREDITS = 2,
  parameter int PROG_START   = 32,
  parameter int PROG_END     = 63
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  credit_return,  // one credit per high cycle
  output fetch_pkg::fetch_pkt_t pkt,
  output logic                  pkt_valid,
  output logic                  halted,
  output logic                  xlat_req,
  output fetch_pkg::laddr_t     xlat_addr,
  input  logic                  xlat_done,
  input  fetch_pkg::paddr_t     xlat_paddr,
  output logic                  rd_en,
  output fetch_pkg::paddr_t     rd_addr,
  input  fetch_pkg::word_t      rd_data,
  output logic                  ch_push,
  output fetch_pkg::char_t      ch_data,
  input  logic                  ch_full
);

  localparam int CW = $clog2(INIT_CREDITS + 1);  // credit counter width

  fetch_pkg::fetch_state_t state;
  fetch_pkg::laddr_t       pc;         // next word to fetch
  logic                    second;     // 1 while fetching word2 of the pair
  logic [CW-1:0]           credits;
  logic                    take_word;  // read data captured and trace char goes out
  logic                    send;       // packet leaves next cycle
  logic                    last_pair;

  assign xlat_addr = pc;  // held stable for the whole walk
  assign rd_en     = (state == fetch_pkg::ST_TRANSLATE) && xlat_done;
  assign rd_addr   = xlat_paddr;
  assign halted    = (state == fetch_pkg::ST_HALT);

  // in READ the ram output stays put, so a full fifo just stalls here
  assign take_word = (state == fetch_pkg::ST_READ) && !ch_full;

  // send straight from READ if a credit is there, else retry from EMIT
  assign send = (credits != '0) &&
                ((take_word && second) || (state == fetch_pkg::ST_EMIT && !pkt_valid));

  assign last_pair = (pkt.pc == fetch_pkg::laddr_t'(PROG_END - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= fetch_pkg::ST_IDLE;
      pc        <= fetch_pkg::laddr_t'(PROG_START);
      second    <= 1'b0;
      credits   <= CW'(INIT_CREDITS);
      pkt_valid <= 1'b0;
      xlat_req  <= 1'b0;
      ch_push   <= 1'b0;
    end else begin
      xlat_req  <= 1'b0;  // single-cycle pulses
      ch_push   <= 1'b0;
      pkt_valid <= send;

      // return and send in one cycle cancel out
      case ({credit_return, send})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: ;
      endcase

      case (state)
        fetch_pkg::ST_IDLE: begin
          if (!ch_full) begin
            ch_push  <= 1'b1;  // 'S'
            xlat_req <= 1'b1;  // first word at PROG_START
            state    <= fetch_pkg::ST_TRANSLATE;
          end
        end
        fetch_pkg::ST_TRANSLATE: begin
          if (xlat_done) state <= fetch_pkg::ST_READ;  // rd_en fires this cycle
        end
        fetch_pkg::ST_READ: begin
          if (take_word) begin
            ch_push <= 1'b1;
            pc      <= pc + 1'b1;
            second  <= !second;
            if (second) begin
              state <= fetch_pkg::ST_EMIT;
            end else begin
              xlat_req <= 1'b1;  // pc already points at word2
              state    <= fetch_pkg::ST_TRANSLATE;
            end
          end
        end
        fetch_pkg::ST_EMIT: begin
          if (pkt_valid) begin  // packet is out this cycle
            if (last_pair) begin
              state <= fetch_pkg::ST_HALT;
            end else begin
              xlat_req <= 1'b1;
              state    <= fetch_pkg::ST_TRANSLATE;
            end
          end
        end
        default: ;  // halt is final
      endcase
    end
  end

  // packet payload and trace char
  always_ff @(posedge clk) begin
    if (state == fetch_pkg::ST_IDLE) begin
      ch_data <= fetch_pkg::CH_START;
    end else if (take_word) begin
      ch_data <= second ? fetch_pkg::CH_SECOND : fetch_pkg::CH_FIRST;
    end
    if (take_word && !second) begin
      pkt.pc    <= pc;
      pkt.word1 <= rd_data;
    end
    if (take_word && second) begin
      pkt.word2 <= rd_data;
    end
  end

  // consumer must not hand back more than it was given
  a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    credits <= INIT_CREDITS);

endmodule

/* uart_tx.sv */
`timescale 1ns/100ps

module uart_tx #(
  parameter int CLKS_PER_BIT = 868
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             ch_valid,
  input  fetch_pkg::char_t ch_head,
  output logic             ch_pop,
  output logic             tx
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

  // 8N1 frame, LSB first
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_t;

  tx_state_t        state;
  logic [CNT_W-1:0] cnt;      // cycles into the current bit
  logic [2:0]       bit_idx;
  fetch_pkg::char_t shift;
  logic             bit_end;

  assign ch_pop  = (state == TX_IDLE) && ch_valid;  // take head when free
  assign bit_end = (cnt == CNT_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= TX_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;  // line idles high
    end else begin
      cnt <= bit_end ? '0 : cnt + 1'b1;
      case (state)
        TX_IDLE: begin
          cnt <= '0;
          if (ch_valid) begin
            tx    <= 1'b0;  // start bit
            state <= TX_START;
          end
        end
        TX_START: begin
          if (bit_end) begin
            tx      <= shift[0];
            bit_idx <= '0;
            state   <= TX_DATA;
          end
        end
        TX_DATA: begin
          if (bit_end) begin
            if (bit_idx == 3'd7) begin
              tx    <= 1'b1;  // stop bit
              state <= TX_STOP;
            end else begin
              tx      <= shift[1];
              bit_idx <= bit_idx + 1'b1;
            end
          end
        end
        default: begin
          if (bit_end) state <= TX_IDLE;
        end
      endcase
    end
  end

  // data shifter
  always_ff @(posedge clk) begin
    if (ch_pop) begin
      shift <= ch_head;
    end else if (state == TX_DATA && bit_end) begin
      shift <= shift >> 1;
    end
  end

endmodule

/* char_fifo.sv */
`timescale 1ns/100ps

module char_fifo #(
  parameter int DEPTH = 16
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             ch_push,
  input  fetch_pkg::char_t ch_data,
  output logic             ch_full,
  output logic             ch_valid,  // head is a real char
  output fetch_pkg::char_t ch_head,
  input  logic             ch_pop
);

  localparam int PW = $clog2(DEPTH);

  fetch_pkg::char_t mem [DEPTH];
  logic [PW-1:0]    wr_ptr;
  logic [PW-1:0]    rd_ptr;
  logic [PW:0]      count;  // 0..DEPTH

  assign ch_full  = (count == (PW + 1)'(DEPTH));
  assign ch_valid = (count != '0);
  assign ch_head  = mem[rd_ptr];  // fall-through head

  always_ff @(posedge clk) begin
    if (ch_push) begin
      mem[wr_ptr] <= ch_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (ch_push) begin
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (ch_pop) begin
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({ch_push, ch_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // both or neither
      endcase
    end
  end

  // writer checks full, the uart checks valid
  a_no_overflow_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    !(ch_push && ch_full) && !(ch_pop && !ch_valid));

endmodule

/* program_ram.sv */
`timescale 1ns/100ps

module program_ram (
  input  logic              clk,
  input  logic              rd_en,
  input  fetch_pkg::paddr_t rd_addr,
  output fetch_pkg::word_t  rd_data
);

  localparam int WORDS = fetch_pkg::NUM_SEGS * fetch_pkg::PAGE_WORDS;  // 96

  // one row of program.mem per physical segment
  fetch_pkg::word_t mem [WORDS];

  initial begin
    $readmemh("program.mem", mem);
  end

  // registered read, data one cycle after rd_en and held until the next read
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

/* mmu_walker.sv */
`timescale 1ns/100ps

module mmu_walker #(
  parameter int PAGE_WORDS = 16
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              xlat_req,
  input  fetch_pkg::laddr_t xlat_addr,
  output logic              xlat_done,
  output fetch_pkg::paddr_t xlat_paddr
);

  localparam int OFF_W = $clog2(PAGE_WORDS);

  logic               walking;   // chain walk in progress
  fetch_pkg::seg_t    seg_cur;   // segment looked at this cycle
  fetch_pkg::lpage_t  page_q;    // page being searched
  logic [OFF_W-1:0]   off_q;
  fetch_pkg::lpage_t  req_page;
  logic [OFF_W-1:0]   req_off;

  // segment base plus offset
  function automatic fetch_pkg::paddr_t phys_addr(input fetch_pkg::seg_t seg,
                                                  input logic [OFF_W-1:0] off);
    phys_addr = fetch_pkg::paddr_t'(seg * PAGE_WORDS + off);
  endfunction

  assign req_page = fetch_pkg::lpage_t'(xlat_addr >> OFF_W);
  assign req_off  = xlat_addr[OFF_W-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      walking   <= 1'b0;
      seg_cur   <= fetch_pkg::START_SEG;
      xlat_done <= 1'b0;
    end else begin
      xlat_done <= 1'b0;
      if (walking) begin
        if (fetch_pkg::CHAIN_PAGE[seg_cur] == page_q) begin
          xlat_done <= 1'b1;  // tag hit
          walking   <= 1'b0;
        end else begin
          seg_cur <= fetch_pkg::CHAIN_NEXT[seg_cur];  // one hop
        end
      end else if (xlat_req) begin
        if (req_page == '0) begin
          xlat_done <= 1'b1;  // page 0 always sits in the start segment
        end else begin
          walking <= 1'b1;
          seg_cur <= fetch_pkg::CHAIN_NEXT[fetch_pkg::START_SEG];
        end
      end
    end
  end

  // request fields and the result
  always_ff @(posedge clk) begin
    if (!walking && xlat_req) begin
      page_q     <= req_page;
      off_q      <= req_off;
      xlat_paddr <= phys_addr(fetch_pkg::START_SEG, req_off);
    end else if (walking) begin
      xlat_paddr <= phys_addr(seg_cur, off_q);  // used only on the hit cycle
    end
  end

  // on the end segment the tag has to hit, or the walk would spin forever
  a_chain_resolves: assert property (@(posedge clk) disable iff (!rst_n)
    walking && (fetch_pkg::CHAIN_NEXT[seg_cur] == seg_cur) |=> xlat_done);

endmodule

/* fetch_pkg.sv */
package fetch_pkg;

  // widths that carry a meaning
  typedef logic [15:0] word_t;   // memory / instruction word
  typedef logic [5:0]  laddr_t;  // logical address, page + offset
  typedef logic [6:0]  paddr_t;  // physical address, segment + offset
  typedef logic [2:0]  seg_t;    // physical segment index
  typedef logic [1:0]  lpage_t;  // logical page number
  typedef logic [7:0]  char_t;   // trace character for the uart

  localparam int PAGE_WORDS = 16;  // words per page and per segment
  localparam int NUM_SEGS   = 6;   // physical segments in program memory

  localparam seg_t START_SEG = 3'd0;  // first segment of the process, holds page 0

  // chain of segments, walked from START_SEG
  // segment 1 closes the chain, 3 and 4 are spare and point at themselves
  localparam seg_t CHAIN_NEXT [NUM_SEGS] = '{
    3'd5,  // 0 -> 5
    3'd1,  // 1 end of chain
    3'd1,  // 2 -> 1
    3'd3,  // spare
    3'd4,  // spare
    3'd2   // 5 -> 2
  };

  // logical page tag held by each segment
  localparam lpage_t CHAIN_PAGE [NUM_SEGS] = '{
    2'd0,
    2'd1,
    2'd2,
    2'd0,  // spare, never reached
    2'd0,  // spare, never reached
    2'd3
  };

  // trace characters
  localparam char_t CH_START  = "S";  // after reset
  localparam char_t CH_FIRST  = "a";  // first word of a pair fetched
  localparam char_t CH_SECOND = "b";  // second word fetched

  // packet handed to the consumer, 38 bits
  typedef struct packed {
    laddr_t pc;     // logical address of word1
    word_t  word1;
    word_t  word2;
  } fetch_pkt_t;

  // fetch controller FSM
  typedef enum logic [2:0] {
    ST_IDLE,       // push 'S', then start
    ST_TRANSLATE,  // waiting on the mmu
    ST_READ,       // read data back, push trace char
    ST_EMIT,       // pair complete, waiting for a credit
    ST_HALT        // end address passed
  } fetch_state_t;

endpackage
